//--- hw/corr_geom_pkg.sv
/*
 * Geometry and word widths of the four-line correlator.
 * Imported by the RTL blocks, the type package and the testbench.
 */

package corr_geom_pkg;

	// input side
	localparam int NUM_LINES = 4;
	localparam int SAMPLE_WIDTH = 4;

	// lags 0, 1 and 2 on every baseline
	localparam int NUM_LAGS = 3;
	localparam int NUM_BASELINES = NUM_LINES*(NUM_LINES-1)/2;
	localparam int NUM_CORR = NUM_BASELINES*NUM_LAGS;

	// signed accumulators and their clamp points
	localparam int ACC_WIDTH = 12;
	localparam int ACC_MAX = (1 << (ACC_WIDTH-1)) - 1;
	localparam int ACC_MIN = -(1 << (ACC_WIDTH-1));

	// sample sets per integration period
	localparam int INTEG_LEN = 64;
	localparam int CNT_WIDTH = 6;

endpackage

//--- hw/corr_types_pkg.sv
/*
 * Structs and enums passed between the correlator blocks.
 * Sample sets come in, labelled sums go out, the bank sits in between.
 */

package corr_types_pkg;
	import corr_geom_pkg::*;

	// one sample per line, line0 in the low bits
	typedef struct packed {
		logic signed [SAMPLE_WIDTH-1:0] line3;
		logic signed [SAMPLE_WIDTH-1:0] line2;
		logic signed [SAMPLE_WIDTH-1:0] line1;
		logic signed [SAMPLE_WIDTH-1:0] line0;
	} sample_set_t;

	typedef struct packed {
		logic signed [ACC_WIDTH-1:0] value;
		logic                        saturated;
	} corr_sum_t;

	typedef struct packed {
		logic [2:0] baseline;
		logic [1:0] lag;
		corr_sum_t  sum;
	} corr_word_t;

	// entry baseline*NUM_LAGS+lag
	typedef corr_sum_t [NUM_CORR-1:0] corr_bank_t;

	typedef enum logic {
		ST_INTEGRATE,
		ST_HOLD
	} ctrl_state_e;

endpackage

//--- hw/lag_delay_line.sv
/*
 * Two-deep history of one input line, shifted on every accepted set.
 * Cleared at the end of a period so lags never reach into the last one.
 */

`timescale 1ns/100ps

module lag_delay_line
	import corr_geom_pkg::*;
(
	input  logic                                    pllclk,
	input  logic                                    reset,
	input  logic                                    shift_i,
	input  logic                                    clear_i,
	input  logic signed [SAMPLE_WIDTH-1:0]          sample_i,
	output logic [NUM_LAGS-1:1][SAMPLE_WIDTH-1:0]   delayed_o
);

	// delayed_o[k] holds the sample k sets back
	always_ff @(posedge pllclk) begin
		if (!reset || clear_i) begin
			delayed_o <= '0;
		end else if (shift_i) begin
			delayed_o <= {delayed_o[NUM_LAGS-2:1], sample_i};
		end
	end

	// clear only comes with the last accept of a period
	a_clear_on_shift: assert property (
		@(posedge pllclk) disable iff (!reset) clear_i |-> shift_i
	) else $error("delay line cleared without an accepted set");

endmodule

//--- hw/baseline_accumulator.sv
/*
 * Products and saturating sums for every baseline and lag.
 * On the period's last accept the finished sums move to captured_o.
 */

`timescale 1ns/100ps

module baseline_accumulator
	import corr_geom_pkg::*, corr_types_pkg::*;
(
	input  logic                                                  pllclk,
	input  logic                                                  reset,
	input  logic                                                  accept_i,
	input  logic                                                  dump_i,
	input  sample_set_t                                           sample_i,
	input  logic [NUM_LINES-1:0][NUM_LAGS-1:1][SAMPLE_WIDTH-1:0]  delayed_i,
	output corr_bank_t                                            captured_o
);

	// hist[line][k] is the sample k sets back, k=0 the current one
	logic signed [SAMPLE_WIDTH-1:0] hist [NUM_LINES][NUM_LAGS];
	corr_bank_t acc_q;
	corr_bank_t acc_d;

	always_comb begin
		hist[0][0] = sample_i.line0;
		hist[1][0] = sample_i.line1;
		hist[2][0] = sample_i.line2;
		hist[3][0] = sample_i.line3;
		for (int l = 0; l < NUM_LINES; l++) begin
			for (int k = 1; k < NUM_LAGS; k++) begin
				hist[l][k] = delayed_i[l][k];
			end
		end
	end

	always_comb begin
		int idx;
		logic signed [2*SAMPLE_WIDTH-1:0] prod;
		logic signed [ACC_WIDTH:0] wide;
		idx = 0;
		acc_d = acc_q;
		for (int a = 0; a < NUM_LINES-1; a++) begin
			for (int b = a+1; b < NUM_LINES; b++) begin
				for (int k = 0; k < NUM_LAGS; k++) begin
					prod = hist[a][0] * hist[b][k];
					wide = acc_q[idx].value + prod;
					// a saturated sum stays pinned for the rest of the period
					if (!acc_q[idx].saturated) begin
						if (wide > ACC_MAX) begin
							acc_d[idx].value = ACC_WIDTH'(ACC_MAX);
							acc_d[idx].saturated = 1'b1;
						end else if (wide < ACC_MIN) begin
							acc_d[idx].value = ACC_WIDTH'(ACC_MIN);
							acc_d[idx].saturated = 1'b1;
						end else begin
							acc_d[idx].value = wide[ACC_WIDTH-1:0];
						end
					end
					idx++;
				end
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset || dump_i) begin
			acc_q <= '0;
		end else if (accept_i) begin
			acc_q <= acc_d;
		end
	end

	// last set of the period is folded in before capture
	always_ff @(posedge pllclk) begin
		if (dump_i) begin
			captured_o <= acc_d;
		end
	end

	a_dump_with_accept: assert property (
		@(posedge pllclk) disable iff (!reset) dump_i |-> accept_i
	) else $error("dump without an accepted sample set");

endmodule

//--- hw/integration_timer.sv
/*
 * Counts accepted sample sets modulo the integration length.
 * period_last_o marks the slot of the period's final set.
 */

`timescale 1ns/100ps

module integration_timer
	import corr_geom_pkg::*;
(
	input  logic pllclk,
	input  logic reset,
	input  logic accept_i,
	output logic period_last_o
);

	logic [CNT_WIDTH-1:0] count_q;

	assign period_last_o = (count_q == CNT_WIDTH'(INTEG_LEN-1));

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			count_q <= '0;
		end else if (accept_i) begin
			if (period_last_o) begin
				count_q <= '0;
			end else begin
				count_q <= count_q + 1'b1;
			end
		end
	end

endmodule

//--- hw/correlator_control.sv
/*
 * Input flow control and period boundaries.
 * Holds off the last set of a period while the previous results are
 * still being read out, then issues the dump with that set.
 */

`timescale 1ns/100ps

module correlator_control
	import corr_types_pkg::*;
(
	input  logic pllclk,
	input  logic reset,
	input  logic sample_valid_i,
	input  logic period_last_i,
	input  logic busy_i,
	output logic sample_ready_o,
	output logic dump_o
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	always_comb begin
		state_d = state_q;
		sample_ready_o = 1'b0;
		case (state_q)
			ST_INTEGRATE: begin
				if (period_last_i && busy_i) begin
					state_d = ST_HOLD;
				end else begin
					sample_ready_o = 1'b1;
				end
			end
			ST_HOLD: begin
				if (!busy_i) begin
					state_d = ST_INTEGRATE;
				end
			end
			default: state_d = ST_HOLD;
		endcase
	end

	assign dump_o = sample_valid_i && sample_ready_o && period_last_i;

	// start in hold so the input stays closed through reset
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state_q <= ST_HOLD;
		end else begin
			state_q <= state_d;
		end
	end

	// holding only ever delays a period's last set
	a_hold_closed: assert property (
		@(posedge pllclk) disable iff (!reset)
		state_q == ST_HOLD && busy_i |-> period_last_i && !sample_ready_o
	) else $error("input held off away from a period end");

endmodule

//--- hw/result_readout.sv
/*
 * Keeps one captured period of sums and streams it out in bank order.
 * busy_o covers the span from dump until the last word has gone out.
 */

`timescale 1ns/100ps

module result_readout
	import corr_geom_pkg::*, corr_types_pkg::*;
(
	input  logic       pllclk,
	input  logic       reset,
	input  logic       dump_i,
	input  corr_bank_t captured_i,
	input  logic       result_ready_i,
	output corr_word_t result_o,
	output logic       result_valid_o,
	output logic       busy_o
);

	corr_bank_t bank_q;
	logic [$clog2(NUM_CORR)-1:0] index_q;
	logic load_q;

	// captured_i settles one edge after the dump
	always_ff @(posedge pllclk) begin
		if (load_q) begin
			bank_q <= captured_i;
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			load_q <= 1'b0;
			result_valid_o <= 1'b0;
			busy_o <= 1'b0;
			index_q <= '0;
		end else begin
			load_q <= dump_i;
			if (dump_i) begin
				busy_o <= 1'b1;
			end
			if (load_q) begin
				result_valid_o <= 1'b1;
				index_q <= '0;
			end else if (result_valid_o && result_ready_i) begin
				if (int'(index_q) == NUM_CORR-1) begin
					result_valid_o <= 1'b0;
					busy_o <= 1'b0;
				end else begin
					index_q <= index_q + 1'b1;
				end
			end
		end
	end

	always_comb begin
		result_o.baseline = 3'(int'(index_q) / NUM_LAGS);
		result_o.lag = 2'(int'(index_q) % NUM_LAGS);
		result_o.sum = bank_q[index_q];
	end

	a_hold_word: assert property (
		@(posedge pllclk) disable iff (!reset)
		result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o)
	) else $error("result word changed while stalled");

endmodule

//--- hw/correlator_top.sv
/*
 * Four-line real cross-correlator, 6 baselines by 3 lags.
 * Sample sets in and labelled sums out, both on valid/ready streams.
 */

`timescale 1ns/100ps

module correlator_top
	import corr_geom_pkg::*, corr_types_pkg::*;
(
	input  logic        pllclk,
	input  logic        reset,
	input  sample_set_t sample_i,
	input  logic        sample_valid_i,
	output logic        sample_ready_o,
	output corr_word_t  result_o,
	output logic        result_valid_o,
	input  logic        result_ready_i
);

	logic accept;
	logic dump;
	logic period_last;
	logic busy;
	corr_bank_t captured;
	logic signed [SAMPLE_WIDTH-1:0] line_sample [NUM_LINES];
	logic [NUM_LINES-1:0][NUM_LAGS-1:1][SAMPLE_WIDTH-1:0] delayed;

	assign accept = sample_valid_i && sample_ready_o;

	assign line_sample[0] = sample_i.line0;
	assign line_sample[1] = sample_i.line1;
	assign line_sample[2] = sample_i.line2;
	assign line_sample[3] = sample_i.line3;

	for (genvar g = 0; g < NUM_LINES; g++) begin : g_line
		lag_delay_line u_delay (
			.pllclk(pllclk),
			.reset(reset),
			.shift_i(accept),
			.clear_i(dump),
			.sample_i(line_sample[g]),
			.delayed_o(delayed[g])
		);
	end

	baseline_accumulator u_acc (
		.pllclk(pllclk),
		.reset(reset),
		.accept_i(accept),
		.dump_i(dump),
		.sample_i(sample_i),
		.delayed_i(delayed),
		.captured_o(captured)
	);

	integration_timer u_timer (
		.pllclk(pllclk),
		.reset(reset),
		.accept_i(accept),
		.period_last_o(period_last)
	);

	correlator_control u_ctrl (
		.pllclk(pllclk),
		.reset(reset),
		.sample_valid_i(sample_valid_i),
		.period_last_i(period_last),
		.busy_i(busy),
		.sample_ready_o(sample_ready_o),
		.dump_o(dump)
	);

	result_readout u_readout (
		.pllclk(pllclk),
		.reset(reset),
		.dump_i(dump),
		.captured_i(captured),
		.result_ready_i(result_ready_i),
		.result_o(result_o),
		.result_valid_o(result_valid_o),
		.busy_o(busy)
	);

endmodule

//--- testbench/tb_clock_gen.sv
/*
 * Clock and reset for the correlator testbench.
 * pllclk runs at a 40 ns period, reset is low over the first two rising edges.
 */

`timescale 1ns/100ps

module tb_clock_gen (
	output logic pllclk,
	output logic reset
);

	initial begin
		pllclk = 1'b0;
		forever #20 pllclk = ~pllclk;
	end

	initial begin
		reset = 1'b0;
		repeat (2) @(posedge pllclk);
		// release on a falling edge, away from the DUT's sampling edge
		@(negedge pllclk);
		reset = 1'b1;
	end

endmodule

//--- testbench/tb_correlator.sv
/*
 * Testbench for correlator_top. Random sample sets and output back-pressure
 * from a fixed-seed LFSR, expected sums from a behavioural model of the
 * correlation rule, one saturating period and two slowly read periods.
 */

`timescale 1ns/100ps

module tb_correlator
	import corr_geom_pkg::*, corr_types_pkg::*;
();

	localparam int NUM_PERIODS = 7;
	localparam int SAT_PERIOD = 2;
	localparam int SLOW_FIRST = 4;
	localparam int SLOW_LAST = 5;
	localparam int WAIT_LIMIT = 4000;
	localparam logic [31:0] LFSR_SEED = 32'h5db75723;

	logic pllclk;
	logic reset;
	sample_set_t sample_i;
	logic sample_valid_i;
	logic sample_ready_o;
	corr_word_t result_o;
	logic result_valid_o;
	logic result_ready_i;

	logic [31:0] src_lfsr;
	logic [31:0] sink_lfsr;
	sample_set_t period_sets [INTEG_LEN];
	corr_word_t exp_q [$];
	int errors;
	int timeouts;
	int held_cycles;
	int sat_words;
	bit abort;

	tb_clock_gen clk0 (
		.pllclk(pllclk),
		.reset(reset)
	);

	correlator_top dut0 (
		.pllclk(pllclk),
		.reset(reset),
		.sample_i(sample_i),
		.sample_valid_i(sample_valid_i),
		.sample_ready_o(sample_ready_o),
		.result_o(result_o),
		.result_valid_o(result_valid_o),
		.result_ready_i(result_ready_i)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			bits = {bits[30:0], state[0]};
		end
	endtask

	function automatic int line_value(input sample_set_t s, input int l);
		logic signed [SAMPLE_WIDTH-1:0] v;
		case (l)
			0: v = s.line0;
			1: v = s.line1;
			2: v = s.line2;
			default: v = s.line3;
		endcase
		return int'(v);
	endfunction

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_sum(input corr_sum_t got, input corr_sum_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s sum %0d sat %b, expected %0d sat %b", $time, what,
				$signed(got.value), got.saturated, $signed(exp.value), exp.saturated);
		end
	endtask

	task automatic compare_word(input corr_word_t got, input corr_word_t exp, input int num);
		string what;
		what = $sformatf("word %0d", num);
		if (got.baseline !== exp.baseline || got.lag !== exp.lag) begin
			errors++;
			$display("[ERROR] %0t: %s is baseline %0d lag %0d, expected baseline %0d lag %0d",
				$time, what, got.baseline, got.lag, exp.baseline, exp.lag);
		end
		compare_sum(got.sum, exp.sum, what);
	endtask

	// reference sums of one finished period, pushed in bank order
	task automatic build_expected();
		int bl;
		int v;
		int term;
		bit sat;
		corr_word_t w;
		bl = 0;
		for (int a = 0; a < NUM_LINES-1; a++) begin
			for (int b = a+1; b < NUM_LINES; b++) begin
				for (int k = 0; k < NUM_LAGS; k++) begin
					v = 0;
					sat = 1'b0;
					for (int n = 0; n < INTEG_LEN; n++) begin
						// history from before the period start reads as zero
						term = 0;
						if (n >= k) begin
							term = line_value(period_sets[n], a) * line_value(period_sets[n-k], b);
						end
						if (!sat) begin
							v += term;
							if (v > ACC_MAX) begin
								v = ACC_MAX;
								sat = 1'b1;
							end else if (v < ACC_MIN) begin
								v = ACC_MIN;
								sat = 1'b1;
							end
						end
					end
					w.baseline = 3'(bl);
					w.lag = 2'(k);
					w.sum.value = ACC_WIDTH'(v);
					w.sum.saturated = sat;
					exp_q.push_back(w);
				end
				bl++;
			end
		end
	endtask

	task automatic make_set(input int period, output sample_set_t s);
		logic [31:0] r;
		if (period == SAT_PERIOD) begin
			draw_bits(src_lfsr, 1, r);
			// lines 0,1 at one extreme and lines 2,3 at the other, or swapped
			s = sample_set_t'(r[0] ? 16'h7788 : 16'h8877);
		end else begin
			draw_bits(src_lfsr, 16, r);
			s = sample_set_t'(r[15:0]);
		end
	endtask

	task automatic send_set(input sample_set_t s, input int seq, output bit ok);
		logic [31:0] r;
		int waited;
		ok = 1'b0;
		waited = 0;
		draw_bits(src_lfsr, 2, r);
		if (r[1:0] == 2'd0) begin
			sample_valid_i = 1'b0;
			@(negedge pllclk);
		end
		sample_i = s;
		sample_valid_i = 1'b1;
		while (sample_ready_o !== 1'b1 && waited < WAIT_LIMIT) begin
			@(negedge pllclk);
			waited++;
		end
		if (sample_ready_o !== 1'b1) begin
			timeouts++;
			abort = 1'b1;
			$display("timed out waiting for the DUT to accept sample set %0d", seq);
		end else begin
			if (waited > 0 && seq % INTEG_LEN == INTEG_LEN-1) begin
				held_cycles += waited;
			end else if (waited > 0) begin
				errors++;
				$display("[ERROR] %0t: set %0d held off %0d cycles mid-period", $time, seq, waited);
			end
			// the set goes in on the rising edge before this one
			@(negedge pllclk);
			ok = 1'b1;
		end
	endtask

	task automatic receive_word(input bit slow, input int num, output corr_word_t got,
			output bit ok);
		logic [31:0] r;
		int waited;
		ok = 1'b0;
		waited = 0;
		while (!ok && !abort && waited < WAIT_LIMIT) begin
			draw_bits(sink_lfsr, 3, r);
			result_ready_i = slow ? (r[2:0] == 3'd0) : (r[2:0] != 3'd0);
			if (result_valid_o === 1'b1 && result_ready_i) begin
				got = result_o;
				ok = 1'b1;
			end
			@(negedge pllclk);
			waited++;
		end
		if (!ok && !abort) begin
			timeouts++;
			abort = 1'b1;
			$display("timed out waiting for result word %0d", num);
		end
	endtask

	task automatic produce_all();
		sample_set_t s;
		bit ok;
		for (int p = 0; p < NUM_PERIODS && !abort; p++) begin
			for (int n = 0; n < INTEG_LEN && !abort; n++) begin
				make_set(p, s);
				send_set(s, p*INTEG_LEN + n, ok);
				if (ok) begin
					period_sets[n] = s;
					if (n == INTEG_LEN-1) begin
						build_expected();
					end
				end
			end
		end
		sample_valid_i = 1'b0;
	endtask

	task automatic consume_all();
		corr_word_t got;
		bit ok;
		bit slow;
		for (int w = 0; w < NUM_PERIODS*NUM_CORR && !abort; w++) begin
			// slow readout here backs up the next period's last set
			slow = (w / NUM_CORR >= SLOW_FIRST) && (w / NUM_CORR <= SLOW_LAST);
			receive_word(slow, w, got, ok);
			if (ok) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("[ERROR] %0t: word %0d arrived with no result expected", $time, w);
				end else begin
					compare_word(got, exp_q.pop_front(), w);
				end
				if (got.sum.saturated) begin
					sat_words++;
				end
			end
		end
		result_ready_i = 1'b0;
	endtask

	initial begin
		int waited;
		sample_i = '0;
		sample_valid_i = 1'b0;
		result_ready_i = 1'b0;
		errors = 0;
		timeouts = 0;
		held_cycles = 0;
		sat_words = 0;
		abort = 1'b0;
		src_lfsr = LFSR_SEED;
		sink_lfsr = LFSR_SEED;
		// move the sink stream away from the source stream
		for (int i = 0; i < 101; i++) begin
			sink_lfsr = lfsr_step(sink_lfsr);
		end

		@(posedge pllclk);
		@(negedge pllclk);
		compare_flag(sample_ready_o, 1'b0, "sample_ready_o in reset");
		compare_flag(result_valid_o, 1'b0, "result_valid_o in reset");
		waited = 0;
		while (reset !== 1'b1 && waited < WAIT_LIMIT) begin
			@(posedge pllclk);
			waited++;
		end
		if (reset !== 1'b1) begin
			timeouts++;
			abort = 1'b1;
			$display("reset was never released");
		end
		@(negedge pllclk);

		fork
			produce_all();
			consume_all();
		join

		@(negedge pllclk);
		compare_flag(result_valid_o, 1'b0, "result_valid_o after the last word");
		if (!abort) begin
			if (exp_q.size() != 0) begin
				errors++;
				$display("%0d expected result words never arrived", exp_q.size());
			end
			if (sat_words == 0) begin
				errors++;
				$display("no saturated sum came out of the extreme period");
			end
			if (held_cycles == 0) begin
				errors++;
				$display("slow readout never held off the input");
			end
		end

		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
hw/corr_geom_pkg.sv
hw/corr_types_pkg.sv
hw/lag_delay_line.sv
hw/baseline_accumulator.sv
hw/integration_timer.sv
hw/correlator_control.sv
hw/result_readout.sv
hw/correlator_top.sv
testbench/tb_clock_gen.sv
testbench/tb_correlator.sv

//--- Makefile
# Verilator build and run for the correlator testbench

VERILATOR ?= verilator
TOP       ?= tb_correlator
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
